// File: Bender.yml
package:
  name: rvPipe

sources:
  - rvPkg.sv
  - rvDecode.sv
  - rvAlu.sv
  - rvHazard.sv
  - rvCore.sv
  - rvRegFile.sv
  - rvMem.sv
  - rvSystem.sv
  - target: test
    files:
      - rvSystem_sva.sv
      - rvMonitor.sv
      - rvTb.sv

// File: rvAlu.sv
`default_nettype none

module rvAlu (
	input  rvPkg::word_t  a,
	input  rvPkg::word_t  b,
	input  rvPkg::aluOp_t op,
	output rvPkg::word_t  result,
	output logic          equal
);

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);
	assign equal = (a == b);

	always_comb begin
		case (op)
			rvPkg::aluAdd: result = a + b;
			rvPkg::aluSub: result = a - b;
			rvPkg::aluAnd: result = a & b;
			rvPkg::aluOr: result = a | b;
			rvPkg::aluXor: result = a ^ b;
			rvPkg::aluSlt: result = {31'b0, lessThan};
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

// File: rvCases.txt
# T name | P instruction word (hex) | W rd (decimal) value (hex) | E retired count (decimal)
# W lines list the register writes in program order; text after a field is ignored
T arith
P 00c00093 addi x1, x0, 12
P ffb00113 addi x2, x0, -5
P 00700193 addi x3, x0, 7
P 00208233 add x4, x1, x2
P 403082b3 sub x5, x1, x3
P 0030f333 and x6, x1, x3
P 0030e3b3 or x7, x1, x3
P 0020c433 xor x8, x1, x2
P 001124b3 slt x9, x2, x1
P 0020a533 slt x10, x1, x2
P 00100073 ebreak
W 1 0000000c
W 2 fffffffb
W 3 00000007
W 4 00000007
W 5 00000005
W 6 00000004
W 7 0000000f
W 8 fffffff7
W 9 00000001
W 10 00000000
E 11

T forward
P 00500093 addi x1, x0, 5
P 00308113 addi x2, x1, 3
P 001101b3 add x3, x2, x1
P 40218233 sub x4, x3, x2
P 003240b3 xor x1, x4, x3
P 001082b3 add x5, x1, x1
P 0040e333 or x6, x1, x4
P 00100073 ebreak
W 1 00000005
W 2 00000008
W 3 0000000d
W 4 00000005
W 1 00000008
W 5 00000010
W 6 0000000d
E 8

T loadstore
P 12300093 addi x1, x0, 0x123
P 01000113 addi x2, x0, 16
P 00112223 sw x1, 4(x2)
P 00412183 lw x3, 4(x2)
P 00118233 add x4, x3, x1
P 00412423 sw x4, 8(x2)
P 00812283 lw x5, 8(x2)
P 40328333 sub x6, x5, x3
P 00100073 ebreak
W 1 00000123
W 2 00000010
W 3 00000123
W 4 00000246
W 5 00000246
W 6 00000123
E 9

T branch
P 00300093 addi x1, x0, 3
P 00300113 addi x2, x0, 3
P 00208663 beq x1, x2, +12
P 00100293 addi x5, x0, 1
P 00100313 addi x6, x0, 1
P 00c003ef jal x7, +12
P 00100413 addi x8, x0, 1
P 00100493 addi x9, x0, 1
P 00008463 beq x1, x0, +8
P 00138513 addi x10, x7, 1
P 00100073 ebreak
P 00100593 addi x11, x0, 1
W 1 00000003
W 2 00000003
W 7 00000018
W 10 00000019
E 7

// File: rvCore.sv
`default_nettype none

module rvCore #(
	parameter int IMEM_AW = 10,
	parameter int DMEM_AW = 10
) (
	input  logic               CLK,
	input  logic               RSTn,
	output logic [IMEM_AW-1:0] imemAddr,
	input  rvPkg::word_t       imemData,
	output logic [DMEM_AW-1:0] dmemAddr,
	output rvPkg::word_t       dmemWdata,
	output logic               dmemWe,
	input  rvPkg::word_t       dmemRdata,
	output rvPkg::regAddr_t    rfRa1,
	output rvPkg::regAddr_t    rfRa2,
	output rvPkg::regAddr_t    rfWa,
	input  rvPkg::word_t       rfRd1,
	input  rvPkg::word_t       rfRd2,
	output logic               rfWe,
	output rvPkg::word_t       rfWd,
	output logic               halt,
	output logic [31:0]        numInst
);

	rvPkg::word_t pc, fdPc, fdInstr, dePc, deImm, deRd1, deRd2, idImm;
	rvPkg::regAddr_t idRs1, idRs2, idRd, deRs1, deRs2, deRd, emRd, mwRd;
	rvPkg::aluOp_t idAluOp, deAluOp;
	logic idUseImm, idRegWrite, idMemRead, idMemWrite, idBranch, idJump, idHalt;
	logic deUseImm, deRegWrite, deMemRead, deMemWrite, deBranch, deJump, deHalt;
	logic fdValid, deValid, emValid, mwValid;
	logic emRegWrite, emMemRead, emMemWrite, emHalt, mwRegWrite, mwHalt;
	rvPkg::word_t opA, opB, aluB, aluResult, exResult, target;
	rvPkg::word_t emResult, emStoreData, memResult, mwResult;
	logic [1:0] fwdA, fwdB;
	logic aluEqual, taken, stall, halting;

	function automatic rvPkg::word_t fwdMux(input logic [1:0] sel, input rvPkg::word_t regVal);
		rvPkg::word_t val;
		case (sel)
			2'b01: val = memResult;
			2'b10: val = mwResult;
			default: val = regVal;
		endcase
		return val;
	endfunction

	assign imemAddr = pc[IMEM_AW+1:2];

	rvDecode u_decode (
		.instr(fdInstr), .rs1(idRs1), .rs2(idRs2), .rd(idRd), .imm(idImm), .aluOp(idAluOp),
		.useImm(idUseImm), .regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
		.isBranch(idBranch), .isJump(idJump), .isHalt(idHalt)
	);
	assign rfRa1 = idRs1;
	assign rfRa2 = idRs2;

	rvHazard u_hazard (
		.exRs1(deRs1), .exRs2(deRs2), .memRd(emRd), .wbRd(mwRd), .idRs1(idRs1), .idRs2(idRs2),
		.exRd(deRd), .memRegWrite(emValid & emRegWrite), .wbRegWrite(mwValid & mwRegWrite),
		.exMemRead(deValid & deMemRead), .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
	);

	assign opA = fwdMux(fwdA, deRd1);
	assign opB = fwdMux(fwdB, deRd2);
	assign aluB = deUseImm ? deImm : opB;

	rvAlu u_alu (.a(opA), .b(aluB), .op(deAluOp), .result(aluResult), .equal(aluEqual));

	assign exResult = deJump ? dePc + 32'd4 : aluResult;
	assign target = dePc + deImm;
	assign taken = deValid && ((deBranch && aluEqual) || deJump);

	// stores behind an ebreak in write-back must not land
	assign halting = halt || (mwValid && mwHalt);
	assign dmemAddr = emResult[DMEM_AW+1:2];
	assign dmemWdata = emStoreData;
	assign dmemWe = emValid && emMemWrite && !halting;
	assign memResult = emMemRead ? dmemRdata : emResult;

	assign rfWe = mwValid && mwRegWrite && mwRd != '0 && !halt;
	assign rfWa = mwRd;
	assign rfWd = mwResult;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			fdValid <= 1'b0;
			deValid <= 1'b0;
			emValid <= 1'b0;
			mwValid <= 1'b0;
			halt <= 1'b0;
			numInst <= '0;
		end else begin
			if (!halt) begin
				if (taken)
					pc <= target;
				else if (!stall)
					pc <= pc + 32'd4;
			end
			fdValid <= taken ? 1'b0 : (stall ? fdValid : 1'b1);
			deValid <= fdValid && !stall && !taken;
			emValid <= deValid;
			mwValid <= emValid;
			halt <= halting;
			numInst <= numInst + {31'b0, mwValid && !halt};
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			fdPc <= pc;
			fdInstr <= imemData;
		end
		{dePc, deRs1, deRs2, deRd} <= {fdPc, idRs1, idRs2, idRd};
		{deImm, deRd1, deRd2} <= {idImm, rfRd1, rfRd2};
		{deAluOp, deUseImm, deRegWrite, deMemRead} <= {idAluOp, idUseImm, idRegWrite, idMemRead};
		{deMemWrite, deBranch, deJump, deHalt} <= {idMemWrite, idBranch, idJump, idHalt};
		{emRd, emResult, emStoreData} <= {deRd, exResult, opB};
		{emRegWrite, emMemRead, emMemWrite, emHalt} <= {deRegWrite, deMemRead, deMemWrite, deHalt};
		{mwRd, mwResult, mwRegWrite, mwHalt} <= {emRd, memResult, emRegWrite, emHalt};
	end

endmodule

`default_nettype wire

// File: rvDecode.sv
`default_nettype none

module rvDecode (
	input  rvPkg::word_t    instr,
	output rvPkg::regAddr_t rs1,
	output rvPkg::regAddr_t rs2,
	output rvPkg::regAddr_t rd,
	output rvPkg::word_t    imm,
	output rvPkg::aluOp_t   aluOp,
	output logic            useImm,
	output logic            regWrite,
	output logic            memRead,
	output logic            memWrite,
	output logic            isBranch,
	output logic            isJump,
	output logic            isHalt
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rvPkg::word_t immI;
	rvPkg::word_t immS;
	rvPkg::word_t immB;
	rvPkg::word_t immJ;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = immI;
		aluOp = rvPkg::aluAdd;
		useImm = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		isHalt = 1'b0;
		case (opcode)
			rvPkg::opcReg: begin
				regWrite = 1'b1;
				case (funct3)
					rvPkg::f3AddSub:
						aluOp = (funct7 == rvPkg::f7Sub) ? rvPkg::aluSub : rvPkg::aluAdd;
					rvPkg::f3Slt: aluOp = rvPkg::aluSlt;
					rvPkg::f3Xor: aluOp = rvPkg::aluXor;
					rvPkg::f3Or: aluOp = rvPkg::aluOr;
					rvPkg::f3And: aluOp = rvPkg::aluAnd;
					default: aluOp = rvPkg::aluAdd;
				endcase
			end
			rvPkg::opcImm: begin
				regWrite = 1'b1;
				useImm = 1'b1;
			end
			rvPkg::opcLoad: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				memRead = 1'b1;
			end
			rvPkg::opcStore: begin
				imm = immS;
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			rvPkg::opcBranch: begin
				imm = immB;
				isBranch = (funct3 == rvPkg::f3Beq);
			end
			// return address is formed in execute
			rvPkg::opcJal: begin
				imm = immJ;
				isJump = 1'b1;
				regWrite = 1'b1;
			end
			// only ebreak halts and ecall falls through as a no-op
			rvPkg::opcSystem: isHalt = instr[20];
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rvHazard.sv
`default_nettype none

module rvHazard (
	input  rvPkg::regAddr_t exRs1,
	input  rvPkg::regAddr_t exRs2,
	input  rvPkg::regAddr_t memRd,
	input  rvPkg::regAddr_t wbRd,
	input  rvPkg::regAddr_t idRs1,
	input  rvPkg::regAddr_t idRs2,
	input  rvPkg::regAddr_t exRd,
	input  logic            memRegWrite,
	input  logic            wbRegWrite,
	input  logic            exMemRead,
	output logic [1:0]      fwdA,
	output logic [1:0]      fwdB,
	output logic            stall
);

	// 01 selects the memory stage and 10 the write-back stage
	function automatic logic [1:0] fwdSel(input rvPkg::regAddr_t src);
		logic [1:0] sel;
		sel = 2'b00;
		if (memRegWrite && memRd != '0 && memRd == src)
			sel = 2'b01;
		else if (wbRegWrite && wbRd != '0 && wbRd == src)
			sel = 2'b10;
		return sel;
	endfunction

	assign fwdA = fwdSel(exRs1);
	assign fwdB = fwdSel(exRs2);

	// load in execute feeding the instruction in decode
	assign stall = exMemRead && exRd != '0 && (exRd == idRs1 || exRd == idRs2);

endmodule

`default_nettype wire

// File: rvMem.sv
`default_nettype none

module rvMem #(
	parameter int AW = 10
) (
	input  logic          CLK,
	input  logic [AW-1:0] addr,
	output rvPkg::word_t  rdata,
	input  logic          we,
	input  rvPkg::word_t  wdata
);

	rvPkg::word_t mem [2**AW];

	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wdata;
	end

	// asynchronous read
	assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: rvMonitor.sv
`default_nettype none

module rvMonitor (
	input logic            CLK,
	input logic            RSTn,
	input logic            wbValid,
	input rvPkg::regAddr_t wbAddr,
	input rvPkg::word_t    wbData,
	input logic            halt,
	input logic [31:0]     numInst
);

	timeunit 1ns;
	timeprecision 1ps;

	int errors = 0;
	string testName = "";
	int expInst = 0;
	int wbIndex = 0;
	rvPkg::regAddr_t expAddr [$];
	rvPkg::word_t expData [$];

	task automatic startTest(input string name, input int count);
		testName = name;
		expInst = count;
		wbIndex = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic expectWrite(input rvPkg::regAddr_t addr, input rvPkg::word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// write-backs must arrive in program order
	always @(posedge CLK) begin
		if (!RSTn && wbValid) begin
			if (halt) begin
				$display("%s: register x%0d was written while halted", testName, wbAddr);
				errors++;
			end
			if (expAddr.size() == 0) begin
				$display("%s: write-back to x%0d = %h that the test does not expect",
					testName, wbAddr, wbData);
				errors++;
			end else begin
				if (wbAddr !== expAddr[0] || wbData !== expData[0]) begin
					$display("ERROR %s write-back %0d: expected x%0d = %h, actual x%0d = %h",
						testName, wbIndex, expAddr[0], expData[0], wbAddr, wbData);
					errors++;
				end
				expAddr.delete(0);
				expData.delete(0);
			end
			wbIndex++;
		end
	end

	task automatic finishTest();
		if (expAddr.size() != 0) begin
			$display("%s: %0d expected write-backs never happened", testName, expAddr.size());
			errors++;
		end
		if (numInst !== 32'(expInst)) begin
			$display("ERROR %s retired count: expected %0d, actual %0d",
				testName, expInst, numInst);
			errors++;
		end
	endtask

endmodule

`default_nettype wire

// File: rvPipe.f
rvPkg.sv
rvDecode.sv
rvAlu.sv
rvHazard.sv
rvCore.sv
rvRegFile.sv
rvMem.sv
rvSystem.sv
rvSystem_sva.sv
rvMonitor.sv
rvTb.sv

// File: rvPkg.sv
`default_nettype none

package rvPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluSlt = 3'd5
	} aluOp_t;

	// major opcodes
	localparam logic [6:0] opcReg    = 7'b0110011;
	localparam logic [6:0] opcImm    = 7'b0010011;
	localparam logic [6:0] opcLoad   = 7'b0000011;
	localparam logic [6:0] opcStore  = 7'b0100011;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcJal    = 7'b1101111;
	localparam logic [6:0] opcSystem = 7'b1110011;

	// funct3 of register ops and BEQ
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;
	localparam logic [2:0] f3Beq    = 3'b000;

	localparam logic [6:0] f7Sub = 7'b0100000;

endpackage

`default_nettype wire

// File: rvRegFile.sv
`default_nettype none

module rvRegFile (
	input  logic            CLK,
	input  logic            RSTn,
	input  rvPkg::regAddr_t ra1,
	input  rvPkg::regAddr_t ra2,
	input  rvPkg::regAddr_t wa,
	output rvPkg::word_t    rd1,
	output rvPkg::word_t    rd2,
	input  logic            we,
	input  rvPkg::word_t    wd
);

	rvPkg::word_t regs [32];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// x0 reads zero and a same-cycle write passes straight through
	assign rd1 = (ra1 == '0) ? '0 : ((we && ra1 == wa) ? wd : regs[ra1]);
	assign rd2 = (ra2 == '0) ? '0 : ((we && ra2 == wa) ? wd : regs[ra2]);

endmodule

`default_nettype wire

// File: rvSystem.sv
`default_nettype none

module rvSystem #(
	parameter int IMEM_AW = 10,
	parameter int DMEM_AW = 10
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               progWe,
	input  logic [IMEM_AW-1:0] progAddr,
	input  rvPkg::word_t       progData,
	output logic               halt,
	output logic [31:0]        numInst,
	output logic               wbValid,
	output rvPkg::regAddr_t    wbAddr,
	output rvPkg::word_t       wbData
);

	logic [IMEM_AW-1:0] coreImemAddr, imemAddr;
	logic [DMEM_AW-1:0] dmemAddr;
	rvPkg::word_t imemData, dmemWdata, dmemRdata, rfRd1, rfRd2;
	rvPkg::regAddr_t rfRa1, rfRa2;
	logic dmemWe;

	// loader owns the instruction port while writing
	assign imemAddr = progWe ? progAddr : coreImemAddr;

	rvCore #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_core (
		.CLK(CLK), .RSTn(RSTn), .imemAddr(coreImemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe), .dmemRdata(dmemRdata),
		.rfRa1(rfRa1), .rfRa2(rfRa2), .rfWa(wbAddr), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.rfWe(wbValid), .rfWd(wbData), .halt(halt), .numInst(numInst)
	);

	rvRegFile u_regFile (
		.CLK(CLK), .RSTn(RSTn), .ra1(rfRa1), .ra2(rfRa2), .wa(wbAddr),
		.rd1(rfRd1), .rd2(rfRd2), .we(wbValid), .wd(wbData)
	);

	rvMem #(.AW(IMEM_AW)) u_imem (
		.CLK(CLK), .addr(imemAddr), .rdata(imemData), .we(progWe), .wdata(progData)
	);

	rvMem #(.AW(DMEM_AW)) u_dmem (
		.CLK(CLK), .addr(dmemAddr), .rdata(dmemRdata), .we(dmemWe), .wdata(dmemWdata)
	);

endmodule

`default_nettype wire

// File: rvSystem_sva.sv
`default_nettype none

module rvSystemSva (
	input logic            CLK,
	input logic            RSTn,
	input logic            halt,
	input logic [31:0]     numInst,
	input logic            wbValid,
	input rvPkg::regAddr_t wbAddr
);

	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0;

	wbNotX0: assert property (@(posedge CLK) disable iff (RSTn) wbValid |-> wbAddr != '0)
		else begin
			$error("write-back with destination x0");
			failures++;
		end

	// only reset may clear halt
	haltSticky: assert property (@(posedge CLK) (halt && !RSTn) |=> halt)
		else begin
			$error("halt dropped without reset");
			failures++;
		end

	noWbHalted: assert property (@(posedge CLK) disable iff (RSTn) !(wbValid && halt))
		else begin
			$error("write-back while halted");
			failures++;
		end

	// wbAddr and wbData carry no reset value
	resetClears: assert property (@(posedge CLK) RSTn |=> (!halt && !wbValid && numInst == '0))
		else begin
			$error("outputs not cleared by reset");
			failures++;
		end

endmodule

bind rvSystem rvSystemSva u_sva (
	.CLK(CLK), .RSTn(RSTn), .halt(halt), .numInst(numInst), .wbValid(wbValid), .wbAddr(wbAddr)
);

`default_nettype wire

// File: rvTb.sv
`default_nettype none

module rvTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMEM_AW = 10;
	localparam int DMEM_AW = 10;
	// addi x0, x0, 0 fills the slots behind each program
	localparam rvPkg::word_t nopWord = 32'h0000_0013;

	logic CLK = 1'b0;
	logic RSTn;
	logic progWe;
	logic [IMEM_AW-1:0] progAddr;
	rvPkg::word_t progData;
	logic halt;
	logic [31:0] numInst;
	logic wbValid;
	rvPkg::regAddr_t wbAddr;
	rvPkg::word_t wbData;

	// per-test entries index into flat queues of program words and expected writes
	string names [$];
	int progFirst [$];
	int progLen [$];
	int instCount [$];
	rvPkg::word_t progWords [$];
	rvPkg::regAddr_t expRd [$];
	rvPkg::word_t expVal [$];
	int expTest [$];

	int cycles = 0;
	int cycleLimit = 0;
	string current = "";

	always #10 CLK = ~CLK;

	rvSystem #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_dut (
		.CLK(CLK), .RSTn(RSTn), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.halt(halt), .numInst(numInst), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	rvMonitor u_mon (
		.CLK(CLK), .RSTn(RSTn), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
		.halt(halt), .numInst(numInst)
	);

	always @(posedge CLK) begin
		cycles++;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("processor never halted in test %s, stopped after %0d cycles",
				current, cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic nextCycle();
		@(posedge CLK);
		#2;
	endtask

	task automatic readCases();
		int fd;
		int n;
		int last;
		int rd;
		int count;
		string line;
		string name;
		rvPkg::word_t word;
		fd = $fopen("rvCases.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				last = names.size() - 1;
				if (n > 0) begin
					// comment lines fall into the default branch
					case (line[0])
						"T": begin
							n = $sscanf(line, "T %s", name);
							names.push_back(name);
							progFirst.push_back(progWords.size());
							progLen.push_back(0);
							instCount.push_back(0);
						end
						"P": begin
							n = $sscanf(line, "P %h", word);
							progWords.push_back(word);
							progLen[last] += 1;
						end
						"W": begin
							n = $sscanf(line, "W %d %h", rd, word);
							expRd.push_back(rvPkg::regAddr_t'(rd));
							expVal.push_back(word);
							expTest.push_back(last);
						end
						"E": begin
							n = $sscanf(line, "E %d", count);
							instCount[last] = count;
						end
						default: ;
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runTest(input int t);
		current = names[t];
		u_mon.startTest(names[t], instCount[t]);
		foreach (expTest[i])
			if (expTest[i] == t)
				u_mon.expectWrite(expRd[i], expVal[i]);
		nextCycle();
		RSTn = 1'b1;
		// program plus a short no-op tail written while the core sits in reset
		for (int i = 0; i < progLen[t] + 5; i++) begin
			progWe = 1'b1;
			progAddr = IMEM_AW'(i);
			progData = (i < progLen[t]) ? progWords[progFirst[t] + i] : nopWord;
			nextCycle();
		end
		progWe = 1'b0;
		repeat (4) nextCycle();
		RSTn = 1'b0;
		while (!halt)
			nextCycle();
		// room for anything that would slip out behind the ebreak
		repeat (5) nextCycle();
		u_mon.finishTest();
	endtask

	initial begin
		int total;
		RSTn = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		readCases();
		if (names.size() == 0) begin
			$display("no tests could be read from rvCases.txt");
			$display("Test failed");
		end else begin
			foreach (progLen[t])
				cycleLimit += 4 * progLen[t] + 50;
			foreach (names[t])
				runTest(t);
			total = u_mon.errors + u_dut.u_sva.failures;
			$display("%0d tests, %0d check errors, %0d assertion failures",
				names.size(), u_mon.errors, u_dut.u_sva.failures);
			if (total == 0)
				$display("Test passed");
			else
				$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
